// ==== road_desc_ram.sv ====
// road descriptor RAM with double-buffered halves, bank swap and priority register
`timescale 1ns/10ps

module road_desc_ram (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [10:0]                           cpu_addr,
    input  logic [15:0]                           cpu_dout,
    input  logic [1:0]                            cpu_dswn,
    input  logic                                  road_cs,
    input  logic                                  io_cs,
    input  logic                                  vint,
    input  logic [road_gen_pkg::road_ram_aw-1:0]  rd_addr,
    output logic [15:0]                           cpu_din,
    output logic [15:0]                           rd_data,
    output road_gen_pkg::road_mode_e              mode
);
    import road_gen_pkg::*;

    logic [15:0]            mem [0:2**road_ram_aw-1];
    logic                   half;
    logic                   swap_pend;
    logic [1:0]             we;
    logic [road_ram_aw-1:0] cpu_a;
    logic [road_ram_aw-1:0] disp_a;

    assign we    = {2{road_cs}} & ~cpu_dswn;
    assign cpu_a = {half, cpu_addr};
    // fetcher top bit is relative, 0 means the displayed half
    assign disp_a = {rd_addr[road_ram_aw-1] ^ ~half, rd_addr[road_ram_aw-2:0]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half      <= 1'b0;
            swap_pend <= 1'b0;
            mode      <= only_road0;
        end else begin
            if (io_cs && !cpu_dswn[0]) begin
                mode <= road_mode_e'(cpu_dout[1:0]);
            end
            // armed swap takes effect at vertical interrupt
            if (vint && swap_pend) begin
                half      <= ~half;
                swap_pend <= 1'b0;
            end else if (io_cs && cpu_dswn == 2'b11) begin
                swap_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we[0]) begin
            mem[cpu_a][7:0] <= cpu_dout[7:0];
        end
        if (we[1]) begin
            mem[cpu_a][15:8] <= cpu_dout[15:8];
        end
        cpu_din <= mem[cpu_a];
        rd_data <= mem[disp_a];
    end

endmodule

// ==== road_gen.f ====
road_gen_pkg.sv
road_desc_ram.sv
road_line_fetch.sv
road_layer.sv
road_mixer.sv
road_gen.sv
road_gen_checker.sv
road_gen_tb.sv

// ==== road_gen.sv ====
// two-layer road generator top level
`timescale 1ns/10ps

module road_gen (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [10:0]                           cpu_addr,
    input  logic [15:0]                           cpu_dout,
    output logic [15:0]                           cpu_din,
    input  logic [1:0]                            cpu_dswn,
    input  logic                                  road_cs,
    input  logic                                  io_cs,
    input  logic                                  pxl_cen,
    input  logic [8:0]                            v,
    input  logic                                  vint,
    input  logic                                  hs,
    output logic [road_gen_pkg::road_rom_aw-1:0]  rom0_addr,
    input  logic [15:0]                           rom0_data,
    output logic                                  rom0_cs,
    output logic [road_gen_pkg::road_rom_aw-1:0]  rom1_addr,
    input  logic [15:0]                           rom1_data,
    output logic                                  rom1_cs,
    output road_gen_pkg::road_out_t               out
);
    import road_gen_pkg::*;

    logic [road_ram_aw-1:0] rd_addr;
    logic [15:0]            rd_data;
    road_mode_e             mode;
    road_line_t             line;
    road_lpix_t             lpix0;
    road_lpix_t             lpix1;

    road_desc_ram u_ram (
        .clk      (clk),
        .rst      (rst),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_dswn (cpu_dswn),
        .road_cs  (road_cs),
        .io_cs    (io_cs),
        .vint     (vint),
        .rd_addr  (rd_addr),
        .cpu_din  (cpu_din),
        .rd_data  (rd_data),
        .mode     (mode)
    );

    road_line_fetch u_fetch (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hs      (hs),
        .v       (v),
        .rd_data (rd_data),
        .rd_addr (rd_addr),
        .line    (line)
    );

    road_layer u_layer0 (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hs       (hs),
        .idx      (line.idx0),
        .scr      (line.scr0),
        .rom_data (rom0_data),
        .rom_addr (rom0_addr),
        .rom_cs   (rom0_cs),
        .lpix     (lpix0)
    );

    road_layer u_layer1 (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hs       (hs),
        .idx      (line.idx1),
        .scr      (line.scr1),
        .rom_data (rom1_data),
        .rom_addr (rom1_addr),
        .rom_cs   (rom1_cs),
        .lpix     (lpix1)
    );

    road_mixer u_mixer (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hs      (hs),
        .mode    (mode),
        .line    (line),
        .lpix0   (lpix0),
        .lpix1   (lpix1),
        .out     (out)
    );

endmodule

// ==== road_gen_cases.txt ====
# id mode arm idx0 idx1 scr0 scr1 col0 col1 rom0 rom1 column pxl rc
# hex fields except id and column, which are decimal
1 0 1 812 834 600 600 a5c 3c6 0000 0000 40 b4 3
2 0 1 012 034 600 600 a5c 3c6 ff00 0000 40 05 0
3 0 1 012 034 600 600 a5c 3c6 00ff 0000 32 02 0
4 0 1 012 034 600 600 a5c 3c6 ffff 0000 48 2a 2
5 1 1 012 034 600 600 a5c 3c6 00ff ff00 40 02 0
6 1 1 012 034 600 600 a5c 3c6 ffff ff00 40 0d 0
7 2 1 012 034 600 600 a5c 3c6 00ff 0000 40 08 0
8 2 1 012 034 600 000 a5c 3c6 ff00 0000 40 0f 0
9 2 0 812 834 600 600 a5c 3c6 ff00 0000 40 0f 0
10 3 1 012 034 600 600 a5c 3c6 0000 00ff 40 0a 0
11 3 1 012 834 600 600 a5c 3c6 0000 0000 40 92 3

// ==== road_gen_checker.sv ====
// road generator checker comparing pixels, ROM addresses, CPU reads and ROM selects during hs
`timescale 1ns/10ps

module road_gen_checker (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  hs,
    input  logic                                  rom0_cs,
    input  logic                                  rom1_cs,
    input  logic [road_gen_pkg::road_rom_aw-1:0]  rom0_addr,
    input  logic [road_gen_pkg::road_rom_aw-1:0]  rom1_addr,
    input  logic [road_gen_pkg::road_rom_aw-1:0]  exp_rom0,
    input  logic [road_gen_pkg::road_rom_aw-1:0]  exp_rom1,
    input  road_gen_pkg::road_out_t               out,
    input  road_gen_pkg::road_out_t               exp_out,
    input  logic [15:0]                           cpu_din,
    input  logic [15:0]                           exp_din,
    input  logic                                  pix_req,
    input  logic                                  din_req,
    input  logic                                  final_req,
    input  int                                    test_id,
    output int                                    pass_cnt,
    output int                                    fail_cnt
);
    import road_gen_pkg::*;

    logic hs_q;
    logic cs_bad;
    logic ok;

    task automatic count_result(input string name, input int id, input logic good);
        if (good) begin
            $display("%s %0d: pass", name, id);
            pass_cnt <= pass_cnt + 1;
        end else begin
            $display("%s %0d: fail", name, id);
            fail_cnt <= fail_cnt + 1;
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            pass_cnt <= 0;
            fail_cnt <= 0;
            hs_q     <= 1'b0;
            cs_bad   <= 1'b0;
        end else begin
            hs_q <= hs;
            // registered chip selects may still be high on the first hs clock
            if (hs && hs_q && (rom0_cs || rom1_cs)) begin
                cs_bad <= 1'b1;
            end
            if (pix_req) begin
                ok = 1'b1;
                if (out.pxl !== exp_out.pxl) begin
                    $display("error out.pxl expected 0x%h actual 0x%h", exp_out.pxl, out.pxl);
                    ok = 1'b0;
                end
                if (out.rc !== exp_out.rc) begin
                    $display("error out.rc expected 0x%h actual 0x%h", exp_out.rc, out.rc);
                    ok = 1'b0;
                end
                if (rom0_addr !== exp_rom0) begin
                    $display("error rom0_addr expected 0x%h actual 0x%h", exp_rom0, rom0_addr);
                    ok = 1'b0;
                end
                if (rom1_addr !== exp_rom1) begin
                    $display("error rom1_addr expected 0x%h actual 0x%h", exp_rom1, rom1_addr);
                    ok = 1'b0;
                end
                count_result("case", test_id, ok);
            end
            if (din_req) begin
                ok = cpu_din === exp_din;
                if (!ok) begin
                    $display("error cpu_din expected 0x%h actual 0x%h", exp_din, cpu_din);
                end
                count_result("readback", test_id, ok);
            end
            if (final_req) begin
                if (cs_bad) begin
                    $display("a ROM chip select was active while hs was high");
                end
                count_result("hs rom select", 1, !cs_bad);
            end
        end
    end

endmodule

// ==== road_gen_pkg.sv ====
// road generator shared widths, priority-mode encoding and bus structs
package road_gen_pkg;

    // descriptor RAM word address, top bit selects the half
    localparam int road_ram_aw = 12;
    // graphics ROM word address
    localparam int road_rom_aw = 14;
    // descriptor reads per scanline
    localparam int road_fetch_words = 6;

    // layer priority, written by the CPU through the I/O port
    typedef enum logic [1:0] {
        only_road0 = 2'd0,
        road0_prio = 2'd1,
        road1_prio = 2'd2,
        only_road1 = 2'd3
    } road_mode_e;

    // one scanline worth of descriptors
    typedef struct packed {
        logic [11:0] idx0;
        logic [11:0] idx1;
        logic [11:0] scr0;
        logic [11:0] scr1;
        logic [11:0] col0;
        logic [11:0] col1;
    } road_line_t;

    // single layer pixel
    typedef struct packed {
        logic [1:0] pix;
        logic       cent;
    } road_lpix_t;

    // mixed pixel and flags (rc[1] blank, rc[0] not from ROM)
    typedef struct packed {
        logic [7:0] pxl;
        logic [1:0] rc;
    } road_out_t;

endpackage

// ==== road_gen_tb.sv ====
// road generator testbench with video timing, CPU port, ROM models and a case reader
`timescale 1ns/10ps

module road_gen_tb;
    import road_gen_pkg::*;

    // line length and sync width in pixels on a four-line frame
    localparam int line_px  = 80;
    localparam int hs_px    = 8;
    localparam int wait_max = 4000;

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic [10:0]            cpu_addr = '0;
    logic [15:0]            cpu_dout = '0;
    logic [15:0]            cpu_din;
    logic [1:0]             cpu_dswn = 2'b11;
    logic                   road_cs = 1'b0;
    logic                   io_cs = 1'b0;
    logic                   pxl_cen;
    logic                   hs;
    logic                   vint;
    logic [8:0]             v = '0;
    logic [road_rom_aw-1:0] rom0_addr;
    logic [road_rom_aw-1:0] rom1_addr;
    logic [15:0]            rom0_data;
    logic [15:0]            rom1_data;
    logic                   rom0_cs;
    logic                   rom1_cs;
    road_out_t              out;

    // ROM models with the rows in use rewritten by each case
    logic [15:0]            rom0 [0:2**road_rom_aw-1];
    logic [15:0]            rom1 [0:2**road_rom_aw-1];

    // checker requests and expected values
    road_out_t              exp_out = '0;
    logic [road_rom_aw-1:0] exp_rom0 = '0;
    logic [road_rom_aw-1:0] exp_rom1 = '0;
    logic [15:0]            exp_din = '0;
    logic                   pix_req = 1'b0;
    logic                   din_req = 1'b0;
    logic                   final_req = 1'b0;
    int                     test_id = 0;
    int                     pass_cnt;
    int                     fail_cnt;
    int                     ccnt = 0;
    logic                   stop = 1'b0;

    always #10 clk = ~clk;

    assign rom0_data = rom0[rom0_addr];
    assign rom1_data = rom1[rom1_addr];

    // clock counter within the line with pixel enable on odd clocks
    always @(negedge clk) begin
        if (rst) begin
            ccnt <= 0;
            v    <= 9'd0;
        end else if (ccnt == 2 * line_px - 1) begin
            ccnt <= 0;
            v    <= (v == 9'd3) ? 9'd0 : v + 9'd1;
        end else begin
            ccnt <= ccnt + 1;
        end
    end

    assign pxl_cen = !rst && ccnt[0];
    assign hs      = ccnt < 2 * hs_px;
    assign vint    = !rst && v == 9'd0 && ccnt == 0;

    road_gen u_dut (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_din   (cpu_din),
        .cpu_dswn  (cpu_dswn),
        .road_cs   (road_cs),
        .io_cs     (io_cs),
        .pxl_cen   (pxl_cen),
        .v         (v),
        .vint      (vint),
        .hs        (hs),
        .rom0_addr (rom0_addr),
        .rom0_data (rom0_data),
        .rom0_cs   (rom0_cs),
        .rom1_addr (rom1_addr),
        .rom1_data (rom1_data),
        .rom1_cs   (rom1_cs),
        .out       (out)
    );

    road_gen_checker u_chk (
        .clk       (clk),
        .rst       (rst),
        .hs        (hs),
        .rom0_cs   (rom0_cs),
        .rom1_cs   (rom1_cs),
        .rom0_addr (rom0_addr),
        .rom1_addr (rom1_addr),
        .exp_rom0  (exp_rom0),
        .exp_rom1  (exp_rom1),
        .out       (out),
        .exp_out   (exp_out),
        .cpu_din   (cpu_din),
        .exp_din   (exp_din),
        .pix_req   (pix_req),
        .din_req   (din_req),
        .final_req (final_req),
        .test_id   (test_id),
        .pass_cnt  (pass_cnt),
        .fail_cnt  (fail_cnt)
    );

    // one CPU bus cycle where io selects the I/O port instead of the RAM
    task automatic bus_write(input logic io, input logic [10:0] a, input logic [15:0] d,
                             input logic [1:0] lanes);
        @(negedge clk);
        cpu_addr = a;
        cpu_dout = d;
        cpu_dswn = lanes;
        road_cs  = !io;
        io_cs    = io;
        @(negedge clk);
        road_cs  = 1'b0;
        io_cs    = 1'b0;
        cpu_dswn = 2'b11;
    endtask

    task automatic check_readback(input int id, input logic [10:0] a, input logic [15:0] d);
        @(negedge clk);
        cpu_addr = a;
        @(negedge clk);
        test_id = id;
        exp_din = d;
        din_req = 1'b1;
        @(negedge clk);
        din_req = 1'b0;
    endtask

    // same descriptors on every line of the frame
    task automatic write_descriptors(input logic [11:0] i0, input logic [11:0] i1,
                                     input logic [11:0] s0, input logic [11:0] s1,
                                     input logic [11:0] c0, input logic [11:0] c1);
        for (int l = 0; l < 4; l++) begin
            bus_write(1'b0, {3'd0, 8'(l)}, {4'd0, i0}, 2'b00);
            bus_write(1'b0, {3'd1, 8'(l)}, {4'd0, i1}, 2'b00);
        end
        bus_write(1'b0, {2'd1, i0[8:0]}, {4'd0, s0}, 2'b00);
        bus_write(1'b0, {2'd2, i1[8:0]}, {4'd0, s1}, 2'b00);
        bus_write(1'b0, {2'd3, i0[8:0]}, {4'd0, c0}, 2'b00);
        bus_write(1'b0, {2'd3, i1[8:0]}, {4'd0, c1}, 2'b00);
    endtask

    task automatic wait_vint();
        int n;
        n = 0;
        while (!stop) begin
            @(posedge clk);
            if (vint) begin
                return;
            end
            n++;
            if (n > wait_max) begin
                $display("timeout while waiting for the vertical interrupt");
                stop = 1'b1;
            end
        end
    endtask

    // column counts pixels after hs falls on line 2
    task automatic wait_column(input int col);
        int n;
        n = 0;
        while (!stop) begin
            @(posedge clk);
            if (v == 9'd2 && ccnt == 2 * (hs_px + col)) begin
                return;
            end
            n++;
            if (n > wait_max) begin
                $display("timeout while waiting for column %0d", col);
                stop = 1'b1;
            end
        end
    endtask

    initial begin
        int          seed;
        logic [31:0] r;
        int          fd;
        int          n;
        string       text;
        int          id;
        int          col;
        logic [1:0]  mode;
        logic        arm;
        logic [11:0] i0;
        logic [11:0] i1;
        logic [11:0] s0;
        logic [11:0] s1;
        logic [11:0] c0;
        logic [11:0] c1;
        logic [15:0] w0;
        logic [15:0] w1;
        logic [7:0]  epx;
        logic [1:0]  erc;
        logic [11:0] d_i0;
        logic [11:0] d_i1;
        logic [11:0] d_s0;
        logic [11:0] d_s1;
        logic [11:0] h0;
        logic [11:0] h1;

        d_i0 = '0;
        d_i1 = '0;
        d_s0 = '0;
        d_s1 = '0;
        seed = 32'h4c8f;
        for (int i = 0; i < 2**road_rom_aw; i++) begin
            r = $random(seed);
            rom0[i] = r[15:0];
            r = $random(seed);
            rom1[i] = r[15:0];
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // byte lanes on the CPU port
        bus_write(1'b0, 11'h7f0, 16'h1234, 2'b00);
        check_readback(1, 11'h7f0, 16'h1234);
        bus_write(1'b0, 11'h7f0, 16'habcd, 2'b10);
        check_readback(2, 11'h7f0, 16'h12cd);
        bus_write(1'b0, 11'h7f0, 16'h5678, 2'b01);
        check_readback(3, 11'h7f0, 16'h56cd);

        fd = $fopen("road_gen_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file");
            stop = 1'b1;
        end
        while (!stop && $fgets(text, fd) != 0) begin
            if (text.len() > 0 && text.getc(0) != 8'h23) begin
                n = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h %h %d %h %h", id, mode,
                            arm, i0, i1, s0, s1, c0, c1, w0, w1, col, epx, erc);
                if (n == 14) begin
                    bus_write(1'b1, 11'd0, {14'd0, mode}, 2'b10);
                    write_descriptors(i0, i1, s0, s1, c0, c1);
                    if (arm) begin
                        bus_write(1'b1, 11'd0, 16'd0, 2'b11);
                        d_i0 = i0;
                        d_i1 = i1;
                        d_s0 = s0;
                        d_s1 = s1;
                    end
                    // rows of the displayed indices hold the case words
                    for (int c = 0; c < 64; c++) begin
                        rom0[{d_i0[8:1], 6'(c)}] = w0;
                        rom1[{d_i1[8:1], 6'(c)}] = w1;
                    end
                    // counter has stepped once per pixel since hs
                    h0 = d_s0 + 12'(col);
                    h1 = d_s1 + 12'(col);
                    wait_vint();
                    wait_column(col);
                    @(negedge clk);
                    test_id  = id;
                    exp_out  = '{pxl: epx, rc: erc};
                    exp_rom0 = {d_i0[8:1], h0[8:3]};
                    exp_rom1 = {d_i1[8:1], h1[8:3]};
                    pix_req  = 1'b1;
                    @(negedge clk);
                    pix_req  = 1'b0;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        @(negedge clk);
        final_req = 1'b1;
        @(negedge clk);
        final_req = 1'b0;
        repeat (2) @(negedge clk);
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (!stop && fail_cnt == 0 && pass_cnt > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== road_layer.sv ====
// single road layer engine with horizontal counter, ROM addressing and pixel shifter
`timescale 1ns/10ps

module road_layer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  pxl_cen,
    input  logic                                  hs,
    input  logic [11:0]                           idx,
    input  logic [11:0]                           scr,
    input  logic [15:0]                           rom_data,
    output logic [road_gen_pkg::road_rom_aw-1:0]  rom_addr,
    output logic                                  rom_cs,
    output road_gen_pkg::road_lpix_t              lpix
);
    import road_gen_pkg::*;

    logic [11:0] hpos;
    logic [15:0] shifter;
    logic        cent;
    logic        in_span;
    logic        en;

    // drawn span is counter range 0x600..0x7ff
    assign in_span = hpos[11:9] == 3'b011;
    assign en      = !idx[11] && in_span;

    // row from the index, column group from the counter
    assign rom_addr = {idx[8:1], hpos[8:3]};

    // two bit-planes, high byte and low byte
    assign lpix.pix  = {shifter[15], shifter[7]};
    assign lpix.cent = cent;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hpos    <= 12'd0;
            shifter <= 16'd0;
            cent    <= 1'b0;
            rom_cs  <= 1'b0;
        end else if (hs) begin
            hpos    <= scr;
            shifter <= 16'hffff;
            cent    <= 1'b0;
            rom_cs  <= 1'b0;
        end else if (pxl_cen) begin
            rom_cs <= en;
            hpos   <= hpos + 12'd1;
            // sticky until the next line
            if (!in_span || hpos[8:0] == 9'h0ff) begin
                cent <= 1'b1;
            end
            if (hpos[2:0] == 3'd0) begin
                shifter <= en ? rom_data : 16'hffff;
            end else begin
                shifter <= shifter << 1;
            end
        end
    end

endmodule

// ==== road_line_fetch.sv ====
// per-line sequencer reading six road descriptors after horizontal sync
`timescale 1ns/10ps

module road_line_fetch (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  pxl_cen,
    input  logic                                  hs,
    input  logic [8:0]                            v,
    input  logic [15:0]                           rd_data,
    output logic [road_gen_pkg::road_ram_aw-1:0]  rd_addr,
    output road_gen_pkg::road_line_t              line
);
    import road_gen_pkg::*;

    logic [2:0] step;

    // regions 0/1 hold per-line indices, later steps follow those indices
    always_comb begin
        case (step)
            3'd0: rd_addr = {1'b0, 3'd0, v[7:0]};
            3'd1: rd_addr = {1'b0, 3'd1, v[7:0]};
            3'd2: rd_addr = {1'b0, 2'd1, line.idx0[8:0]};
            3'd3: rd_addr = {1'b0, 2'd2, line.idx1[8:0]};
            3'd4: rd_addr = {1'b0, 2'd3, line.idx0[8:0]};
            default: rd_addr = {1'b0, 2'd3, line.idx1[8:0]};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step <= 3'd0;
            line <= '0;
        end else if (pxl_cen) begin
            if (hs) begin
                step <= 3'd0;
            end else begin
                // park once all words are in
                if (step < 3'(road_fetch_words)) begin
                    step <= step + 3'd1;
                end
                case (step)
                    3'd0: line.idx0 <= rd_data[11:0];
                    3'd1: line.idx1 <= rd_data[11:0];
                    3'd2: line.scr0 <= rd_data[11:0];
                    3'd3: line.scr1 <= rd_data[11:0];
                    3'd4: line.col0 <= rd_data[11:0];
                    3'd5: line.col1 <= rd_data[11:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== road_mixer.sv ====
// road layer priority mixer and pixel encoder
`timescale 1ns/10ps

module road_mixer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  logic                      hs,
    input  road_gen_pkg::road_mode_e  mode,
    input  road_gen_pkg::road_line_t  line,
    input  road_gen_pkg::road_lpix_t  lpix0,
    input  road_gen_pkg::road_lpix_t  lpix1,
    output road_gen_pkg::road_out_t   out
);
    import road_gen_pkg::*;

    logic       trans0;
    logic       trans1;
    logic       cfill1;
    logic       sel;
    logic       not_rom;
    logic       blank;
    road_lpix_t shown;
    logic [1:0] code;
    logic [11:0] col_sel;

    // value 3 is transparent inside the span and solid centre fill outside it
    assign trans0 = !lpix0.cent && lpix0.pix == 2'd3;
    assign trans1 = !lpix1.cent && lpix1.pix == 2'd3;
    assign cfill1 = lpix1.cent && lpix1.pix == 2'd3;

    assign not_rom = (line.idx0[11] && line.idx1[11]) ||
                     (line.idx0[11] && mode == only_road0) ||
                     (line.idx1[11] && mode == only_road1);

    assign blank = not_rom ||
                   (trans0 && trans1) ||
                   (trans1 && mode == only_road1) ||
                   (trans0 && mode == only_road0);

    // high picks layer 1
    always_comb begin
        sel = (hs && !not_rom) || mode == only_road1;
        if (mode == road0_prio) begin
            sel = sel ||
                  (trans0 && (cfill1 || lpix1.pix == 2'd1 || lpix1.pix == 2'd2)) ||
                  (!lpix0.cent && lpix0.pix != 2'd0 && lpix1.pix == 2'd0) ||
                  (cfill1 && lpix0.pix != 2'd3);
        end
        if (mode == road1_prio) begin
            sel = sel ||
                  (trans0 && (trans1 || lpix1.pix != 2'd3)) ||
                  cfill1 ||
                  (lpix0.pix != 2'd3 && lpix1.pix == 2'd0);
        end
    end

    assign shown   = sel ? lpix1 : lpix0;
    assign col_sel = sel ? line.col1 : line.col0;

    // centre fill counts as both colour bits
    assign code[0] = shown.pix == 2'd1 || (shown.cent && shown.pix == 2'd3);
    assign code[1] = shown.pix == 2'd2 || (shown.cent && shown.pix == 2'd3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out <= '0;
        end else if (pxl_cen) begin
            if (!blank) begin
                out.pxl <= {4'd0, sel, code, col_sel[{1'b0, sel, code}]};
            end else if (not_rom) begin
                // solid colour from the other layer's index
                out.pxl <= {1'b1, sel ? line.idx0[6:0] : line.idx1[6:0]};
            end else begin
                out.pxl <= {3'b001, sel, col_sel[11:8]};
            end
            out.rc <= {blank, not_rom};
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing -f road_gen.f --top-module road_gen_tb -o road_gen_sim &&
./obj_dir/road_gen_sim > sim.log ||
{ echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "STATUS: PASS" sim.log && exit 0 || exit 1
